// File: design/cdb_writeback.sv
module cdb_writeback
#(
    parameter int NUM_LANES = 3
)
(
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  pj_pkg::rob_wb_t [NUM_LANES-1:0] lane_rob_i,
    output pj_pkg::rob_wb_t                 cdb_o,
    output pj_pkg::reg_wb_t                 reg_wb_o,
    output pj_pkg::flags_t                  flags_o
);

    pj_pkg::rob_wb_t sel_n;
    pj_pkg::rob_wb_t cdb_q;
    pj_pkg::flags_t  flags_q;

    // at most one lane finishes per cycle, so no priority is needed
    always_comb
    begin
        sel_n = '0;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (lane_rob_i[i].cdb.valid)
                sel_n = lane_rob_i[i];
        end
    end

    always_ff @(posedge clk_i)
    begin
        cdb_q <= sel_n;
        if (reset_i)
            cdb_q.cdb.valid <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            flags_q <= '0;
        else if (cdb_q.cdb.valid)
            flags_q <= cdb_q.cdb.flags;
    end

    assign cdb_o        = cdb_q;
    assign reg_wb_o.w_v = cdb_q.cdb.valid;
    assign reg_wb_o.cdb = cdb_q.cdb;
    assign flags_o      = flags_q;

endmodule

// File: design/fu_logic.sv
module fu_logic
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  pj_pkg::exe_op_t exe_op_i,
    output pj_pkg::rob_wb_t logic_rob_o
);

    localparam int MSB = pj_pkg::WORD_W - 1;

    pj_pkg::word_t   op1;
    pj_pkg::word_t   op2;
    pj_pkg::shamt_t  s;
    pj_pkg::shamt_t  s_m1;
    pj_pkg::word_t   and_res;
    pj_pkg::word_t   xor_res;
    pj_pkg::word_t   or_res;
    pj_pkg::word_t   neg_res;
    pj_pkg::word_t   lsls_res;
    pj_pkg::word_t   lsrs_res;
    pj_pkg::word_t   asrs_res;
    pj_pkg::word_t   rors_res;
    pj_pkg::word_t   shl_m1;
    pj_pkg::word_t   shr_m1;
    logic            shl_c;
    logic            shr_c;
    pj_pkg::word_t   result;
    logic            carry;
    pj_pkg::rob_wb_t out_n;
    pj_pkg::rob_wb_t out_q;

    assign op1  = exe_op_i.operand1;
    assign op2  = exe_op_i.operand2;
    assign s    = op2[4:0];
    assign s_m1 = s - 5'd1;

    assign and_res = op1 & op2;
    assign xor_res = op1 ^ op2;
    assign or_res  = op1 | op2;
    assign neg_res = ~op2;

    assign lsls_res = op1 << s;
    assign lsrs_res = op1 >> s;
    assign asrs_res = $signed(op1) >>> s;
    // shift by 32 gives zero, so s of 0 leaves op1 unchanged
    assign rors_res = (op1 >> s) | (op1 << (6'd32 - {1'b0, s}));

    // last bit shifted out sits at one position short of the full shift
    assign shl_m1 = op1 << s_m1;
    assign shr_m1 = op1 >> s_m1;
    assign shl_c  = (s != '0) && shl_m1[MSB];
    assign shr_c  = (s != '0) && shr_m1[0];

    always_comb
    begin
        result = and_res;
        carry  = 1'b0;
        unique case (exe_op_i.opcode)
            pj_pkg::AND_OP:  result = and_res;
            pj_pkg::XOR_OP:  result = xor_res;
            pj_pkg::OR_OP:   result = or_res;
            pj_pkg::NEG_OP:  result = neg_res;
            pj_pkg::LSLS_OP:
            begin
                result = lsls_res;
                carry  = shl_c;
            end
            pj_pkg::LSRS_OP:
            begin
                result = lsrs_res;
                carry  = shr_c;
            end
            pj_pkg::ASRS_OP:
            begin
                result = asrs_res;
                carry  = shr_c;
            end
            pj_pkg::RORS_OP:
            begin
                result = rors_res;
                carry  = rors_res[MSB];
            end
        endcase
    end

    always_comb
    begin
        out_n.rob_dest   = exe_op_i.rob_dest;
        out_n.cdb.valid  = exe_op_i.valid;
        out_n.cdb.dest   = exe_op_i.reg_dest;
        out_n.cdb.flags  = {carry, result[MSB], result == '0, 1'b0};
        out_n.cdb.result = result;
    end

    always_ff @(posedge clk_i)
    begin
        out_q <= out_n;
        if (reset_i)
            out_q.cdb.valid <= 1'b0;
    end

    assign logic_rob_o = out_q;

endmodule

// File: design/logic_cluster_top.sv
module logic_cluster_top
#(
    parameter int NUM_LANES = 3
)
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_v_i,
    input  pj_pkg::issue_op_t issue_op_i,
    output pj_pkg::rob_wb_t   cdb_o,
    output pj_pkg::flags_t    flags_o
);

    pj_pkg::preg_idx_t               rd_idx_a;
    pj_pkg::preg_idx_t               rd_idx_b;
    pj_pkg::word_t                   rd_data_a;
    pj_pkg::word_t                   rd_data_b;
    pj_pkg::exe_op_t [NUM_LANES-1:0] lane_op;
    pj_pkg::rob_wb_t [NUM_LANES-1:0] lane_rob;
    pj_pkg::reg_wb_t                 reg_wb;

    logic_issue #(
        .NUM_LANES (NUM_LANES)
    ) u_issue (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_v_i   (issue_v_i),
        .issue_op_i  (issue_op_i),
        .rd_idx_a_o  (rd_idx_a),
        .rd_idx_b_o  (rd_idx_b),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .lane_op_o   (lane_op)
    );

    phys_regfile u_regfile (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_idx_a_i  (rd_idx_a),
        .rd_idx_b_i  (rd_idx_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wb_i        (reg_wb)
    );

    for (genvar g = 0; g < NUM_LANES; g++)
    begin : lanes
        fu_logic u_fu (
            .clk_i       (clk_i),
            .reset_i     (reset_i),
            .exe_op_i    (lane_op[g]),
            .logic_rob_o (lane_rob[g])
        );
    end

    cdb_writeback #(
        .NUM_LANES (NUM_LANES)
    ) u_wb (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .lane_rob_i (lane_rob),
        .cdb_o      (cdb_o),
        .reg_wb_o   (reg_wb),
        .flags_o    (flags_o)
    );

endmodule

// File: design/logic_issue.sv
module logic_issue
#(
    parameter int NUM_LANES = 3
)
(
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 issue_v_i,
    input  pj_pkg::issue_op_t                    issue_op_i,
    output pj_pkg::preg_idx_t                    rd_idx_a_o,
    output pj_pkg::preg_idx_t                    rd_idx_b_o,
    input  pj_pkg::word_t                        rd_data_a_i,
    input  pj_pkg::word_t                        rd_data_b_i,
    output pj_pkg::exe_op_t [NUM_LANES-1:0]      lane_op_o
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] lane_ptr_q;
    logic [PTR_W-1:0] lane_sel_q;
    pj_pkg::exe_op_t  issue_n;
    pj_pkg::exe_op_t  issue_q;

    assign rd_idx_a_o = issue_op_i.src1;
    assign rd_idx_b_o = issue_op_i.src2;

    always_comb
    begin
        issue_n.valid    = issue_v_i;
        issue_n.opcode   = issue_op_i.opcode;
        issue_n.operand1 = rd_data_a_i;
        issue_n.operand2 = issue_op_i.imm_v ? issue_op_i.imm : rd_data_b_i;
        issue_n.rob_dest = issue_op_i.rob_dest;
        issue_n.reg_dest = issue_op_i.reg_dest;
    end

    // round-robin pointer, moves only on accepted instructions
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            lane_ptr_q <= '0;
        else if (issue_v_i)
        begin
            if (lane_ptr_q == PTR_W'(NUM_LANES - 1))
                lane_ptr_q <= '0;
            else
                lane_ptr_q <= lane_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        issue_q    <= issue_n;
        lane_sel_q <= lane_ptr_q;
        if (reset_i)
            issue_q.valid <= 1'b0;
    end

    // one shared payload, valid steered to the chosen slot
    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            lane_op_o[i]       = issue_q;
            lane_op_o[i].valid = issue_q.valid && (lane_sel_q == PTR_W'(i));
        end
    end

endmodule

// File: design/phys_regfile.sv
module phys_regfile
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  pj_pkg::preg_idx_t rd_idx_a_i,
    input  pj_pkg::preg_idx_t rd_idx_b_i,
    output pj_pkg::word_t     rd_data_a_o,
    output pj_pkg::word_t     rd_data_b_o,
    input  pj_pkg::reg_wb_t   wb_i
);

    pj_pkg::word_t regs_q [pj_pkg::NUM_PREGS];
    logic          hit_a;
    logic          hit_b;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < pj_pkg::NUM_PREGS; i++)
                regs_q[i] <= '0;
        end
        else if (wb_i.w_v)
        begin
            regs_q[wb_i.cdb.dest] <= wb_i.cdb.result;
        end
    end

    // write-through bypass, result visible in its own writeback cycle
    assign hit_a = wb_i.w_v && (wb_i.cdb.dest == rd_idx_a_i);
    assign hit_b = wb_i.w_v && (wb_i.cdb.dest == rd_idx_b_i);

    assign rd_data_a_o = hit_a ? wb_i.cdb.result : regs_q[rd_idx_a_i];
    assign rd_data_b_o = hit_b ? wb_i.cdb.result : regs_q[rd_idx_b_i];

endmodule

// File: design/pj_pkg.sv
package pj_pkg;

    localparam int WORD_W    = 32;
    localparam int NUM_PREGS = 64;
    localparam int ROB_DEPTH = 32;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_idx_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [4:0]                   shamt_t;
    // C, N, Z, V from bit 3 down
    typedef logic [3:0]                   flags_t;
    typedef logic [2:0]                   opcode_t;

    localparam opcode_t AND_OP  = 3'd0;
    localparam opcode_t XOR_OP  = 3'd1;
    localparam opcode_t OR_OP   = 3'd2;
    localparam opcode_t NEG_OP  = 3'd3;
    localparam opcode_t LSLS_OP = 3'd4;
    localparam opcode_t LSRS_OP = 3'd5;
    localparam opcode_t ASRS_OP = 3'd6;
    localparam opcode_t RORS_OP = 3'd7;

    typedef struct packed {
        opcode_t   opcode;
        preg_idx_t src1;
        preg_idx_t src2;
        logic      imm_v;
        word_t     imm;
        rob_idx_t  rob_dest;
        preg_idx_t reg_dest;
    } issue_op_t;

    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        word_t     operand1;
        word_t     operand2;
        rob_idx_t  rob_dest;
        preg_idx_t reg_dest;
    } exe_op_t;

    typedef struct packed {
        logic      valid;
        preg_idx_t dest;
        flags_t    flags;
        word_t     result;
    } cdb_t;

    typedef struct packed {
        rob_idx_t rob_dest;
        cdb_t     cdb;
    } rob_wb_t;

    typedef struct packed {
        logic w_v;
        cdb_t cdb;
    } reg_wb_t;

endpackage

// File: run.sh
#!/bin/sh
# build and run the logic cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module logic_cluster_tb \
    -f vlog.f -o logic_cluster_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/logic_cluster_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
exit 0

// File: tb/logic_cluster_chk.sv
module logic_cluster_chk
#(
    parameter int NUM_LANES = 3
)
(
    input logic                            clk_i,
    input logic                            reset_i,
    input logic                            issue_v_i,
    input pj_pkg::rob_wb_t [NUM_LANES-1:0] lane_rob_i,
    input logic                            cdb_valid_i
);

    logic [NUM_LANES-1:0] lane_v;
    int                   fail_cnt = 0;

    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
            lane_v[i] = lane_rob_i[i].cdb.valid;
    end

    a_one_lane: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(lane_v))
        else
        begin
            $error("more than one lane output valid in the same cycle");
            fail_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk_i) reset_i |=> !cdb_valid_i)
        else
        begin
            $error("cdb_o valid right after reset");
            fail_cnt++;
        end

    // fixed three edge latency from issue to broadcast
    a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
                                cdb_valid_i == $past(issue_v_i, 3))
        else
        begin
            $error("cdb_o valid does not follow issue_v_i by three edges");
            fail_cnt++;
        end

endmodule

bind logic_cluster_top logic_cluster_chk #(
    .NUM_LANES (NUM_LANES)
) u_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .issue_v_i   (issue_v_i),
    .lane_rob_i  (lane_rob),
    .cdb_valid_i (cdb_o.cdb.valid)
);

// File: tb/logic_cluster_tb.sv
module logic_cluster_tb;

    logic              clk_i;
    logic              reset_i;
    logic              issue_v_i;
    pj_pkg::issue_op_t issue_op_i;
    pj_pkg::rob_wb_t   cdb_o;
    pj_pkg::flags_t    flags_o;

    pj_pkg::word_t     model [pj_pkg::NUM_PREGS];
    int                last_wr [pj_pkg::NUM_PREGS];
    pj_pkg::rob_wb_t   exp_q [$];
    int                due_q [$];
    pj_pkg::rob_idx_t  next_rob;
    int                cyc = 0;
    int                drv_errors = 0;
    int                cmp_errors = 0;
    int                n_records = 0;

    logic_cluster_top #(
        .NUM_LANES (3)
    ) dut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .issue_v_i  (issue_v_i),
        .issue_op_i (issue_op_i),
        .cdb_o      (cdb_o),
        .flags_o    (flags_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
        cyc <= cyc + 1;

    // expected {flags, result}, flags as C N Z V
    function automatic logic [35:0] ref_calc(input pj_pkg::opcode_t op,
                                             input pj_pkg::word_t a,
                                             input pj_pkg::word_t b);
        int            s;
        pj_pkg::word_t r;
        logic          c;
        s = int'(b[4:0]);
        c = 1'b0;
        r = '0;
        case (op)
            pj_pkg::AND_OP: r = a & b;
            pj_pkg::XOR_OP: r = a ^ b;
            pj_pkg::OR_OP:  r = a | b;
            pj_pkg::NEG_OP: r = ~b;
            pj_pkg::LSLS_OP:
            begin
                r = a << s;
                if (s != 0)
                    c = a[32 - s];
            end
            pj_pkg::LSRS_OP:
            begin
                r = a >> s;
                if (s != 0)
                    c = a[s - 1];
            end
            pj_pkg::ASRS_OP:
            begin
                r = $signed(a) >>> s;
                if (s != 0)
                    c = a[s - 1];
            end
            default:
            begin
                // rotate one place at a time
                r = a;
                for (int k = 0; k < s; k++)
                    r = {r[0], r[31:1]};
                c = r[31];
            end
        endcase
        return {c, r[31], r == '0, 1'b0, r};
    endfunction

    // producer must be at least on the CDB
    function automatic logic src_ready(input pj_pkg::preg_idx_t r);
        return (cyc - last_wr[r]) >= 3;
    endfunction

    function automatic pj_pkg::preg_idx_t pick_src();
        pj_pkg::preg_idx_t r;
        r = pj_pkg::preg_idx_t'($urandom_range(63, 0));
        for (int k = 0; k < pj_pkg::NUM_PREGS; k++)
        begin
            if (src_ready(r))
                return r;
            r++;
        end
        return r;
    endfunction

    task automatic apply(input pj_pkg::opcode_t op, input pj_pkg::preg_idx_t src1,
                         input pj_pkg::preg_idx_t src2, input logic imm_v,
                         input pj_pkg::word_t imm, input pj_pkg::preg_idx_t dest);
        logic [35:0]     calc;
        pj_pkg::rob_wb_t rec;
        if (!src_ready(src1) || (!imm_v && !src_ready(src2)))
        begin
            $display("source register read before its producer reached the CDB, cycle %0d", cyc);
            drv_errors++;
        end
        calc = ref_calc(op, model[src1], imm_v ? imm : model[src2]);
        rec.rob_dest = next_rob;
        rec.cdb = {1'b1, dest, calc[35:32], calc[31:0]};
        exp_q.push_back(rec);
        due_q.push_back(cyc + 3);
        model[dest] = calc[31:0];
        last_wr[dest] = cyc;
        issue_v_i = 1'b1;
        issue_op_i = {op, src1, src2, imm_v, imm, next_rob, dest};
        next_rob++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk_i);
            issue_v_i = 1'b0;
            issue_op_i = '0;
        end
    endtask

    task automatic issue_random(input int lo, input int hi);
        logic          imm_v;
        pj_pkg::word_t imm;
        @(negedge clk_i);
        imm_v = $urandom_range(1, 0) == 1;
        imm = $urandom;
        // counts at the edges of the range
        case ($urandom_range(5, 0))
            0: imm[4:0] = 5'd0;
            1: imm[4:0] = 5'd1;
            2: imm[4:0] = 5'd31;
            default: ;
        endcase
        apply(pj_pkg::opcode_t'($urandom_range(hi, lo)), pick_src(), pick_src(), imm_v, imm,
              pj_pkg::preg_idx_t'($urandom_range(63, 0)));
    endtask

    initial
    begin : check_loop
        pj_pkg::rob_wb_t rec;
        pj_pkg::flags_t  exp_flags;
        int              due;
        exp_flags = '0;
        forever
        begin
            @(negedge clk_i);
            if (!reset_i)
            begin
                if (flags_o !== exp_flags)
                begin
                    $display("Fail flags_o: got %h, expected %h", flags_o, exp_flags);
                    cmp_errors++;
                end
                if (cdb_o.cdb.valid !== 1'b0)
                begin
                    if (exp_q.size() == 0)
                    begin
                        $display("cdb_o carried a record while none was outstanding");
                        cmp_errors++;
                    end
                    else
                    begin
                        rec = exp_q.pop_front();
                        due = due_q.pop_front();
                        n_records++;
                        if (cdb_o !== rec)
                        begin
                            $display("Fail cdb_o: got %h, expected %h", cdb_o, rec);
                            cmp_errors++;
                        end
                        if (due != cyc)
                        begin
                            $display("record for rob entry %0d came at cycle %0d, not %0d",
                                     rec.rob_dest, cyc, due);
                            cmp_errors++;
                        end
                        exp_flags = rec.cdb.flags;
                    end
                end
                else if (due_q.size() != 0 && due_q[0] <= cyc)
                begin
                    $display("record for rob entry %0d never appeared on cdb_o",
                             exp_q[0].rob_dest);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                    cmp_errors++;
                end
            end
        end
    end

    initial
    begin
        int wait_cnt;
        int counts [4];
        counts = '{0, 1, 31, 17};
        void'($urandom(32'h46b7deb7));
        reset_i    = 1'b1;
        issue_v_i  = 1'b0;
        issue_op_i = '0;
        next_rob   = '0;
        for (int i = 0; i < pj_pkg::NUM_PREGS; i++)
        begin
            model[i]   = '0;
            last_wr[i] = -100;
        end
        repeat (16) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);
        if (cdb_o.cdb.valid !== 1'b0 || flags_o !== '0)
        begin
            $display("Fail cdb_o.cdb.valid, flags_o after reset: got %h, %h, expected 0, 0",
                     cdb_o.cdb.valid, flags_o);
            drv_errors++;
        end
        // unwritten registers on both read ports
        apply(pj_pkg::AND_OP, 6'd9, 6'd12, 1'b1, 32'hFFFF_FFFF, 6'd30);
        @(negedge clk_i);
        apply(pj_pkg::AND_OP, 6'd9, 6'd12, 1'b0, '0, 6'd31);
        for (int i = 0; i < pj_pkg::NUM_PREGS; i++)
        begin
            @(negedge clk_i);
            apply(pj_pkg::NEG_OP, pick_src(), 6'd0, 1'b1, $urandom, pj_pkg::preg_idx_t'(i));
        end
        // negative operands, r1 = 8000_0001 and r2 = c3a5_f00f
        idle_cycles(3);
        @(negedge clk_i);
        apply(pj_pkg::NEG_OP, 6'd0, 6'd0, 1'b1, 32'h7FFF_FFFE, 6'd1);
        @(negedge clk_i);
        apply(pj_pkg::NEG_OP, 6'd0, 6'd0, 1'b1, 32'h3C5A_0FF0, 6'd2);
        idle_cycles(2);
        for (int op = 4; op < 8; op++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                @(negedge clk_i);
                apply(pj_pkg::opcode_t'(op), pj_pkg::preg_idx_t'(1 + k % 2), 6'd0, 1'b1,
                      pj_pkg::word_t'(counts[k / 2]), 6'd40);
            end
        end
        repeat (80)
        begin
            issue_random(0, 3);
            if ($urandom_range(3, 0) == 0)
                idle_cycles(1);
        end
        repeat (80)
        begin
            issue_random(4, 7);
            if ($urandom_range(3, 0) == 0)
                idle_cycles(2);
        end
        // consumers in the producer's CDB cycle, port A then port B
        idle_cycles(3);
        @(negedge clk_i);
        apply(pj_pkg::NEG_OP, 6'd0, 6'd0, 1'b1, 32'h5A5A_0F0F, 6'd20);
        idle_cycles(2);
        @(negedge clk_i);
        apply(pj_pkg::OR_OP, 6'd20, 6'd0, 1'b1, 32'h0000_0000, 6'd21);
        @(negedge clk_i);
        apply(pj_pkg::NEG_OP, 6'd0, 6'd0, 1'b1, 32'h0123_8000, 6'd22);
        idle_cycles(2);
        @(negedge clk_i);
        apply(pj_pkg::XOR_OP, 6'd23, 6'd22, 1'b0, '0, 6'd24);
        repeat (300) issue_random(0, 7);
        idle_cycles(1);
        for (wait_cnt = 0; exp_q.size() != 0 && wait_cnt < 20; wait_cnt++)
            @(negedge clk_i);
        if (exp_q.size() != 0)
        begin
            $display("timed out waiting for %0d outstanding CDB records", exp_q.size());
            drv_errors++;
        end
        // flags hold through idle cycles
        idle_cycles(4);
        $display("records %0d, driver errors %0d, compare errors %0d, assertion errors %0d",
                 n_records, drv_errors, cmp_errors, dut.u_chk.fail_cnt);
        if (drv_errors + cmp_errors + dut.u_chk.fail_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: vlog.f
design/pj_pkg.sv
design/phys_regfile.sv
design/logic_issue.sv
design/fu_logic.sv
design/cdb_writeback.sv
design/logic_cluster_top.sv
tb/logic_cluster_chk.sv
tb/logic_cluster_tb.sv
